/* hw/ex1_pkg.sv */
`default_nettype none

package ex1_pkg;

    // data and address word
    typedef logic [31:0] word_t;

    // architectural register index where r0 is hardwired to zero
    typedef logic [4:0] reg_idx_t;

    // exception code as reported to the commit stage
    typedef logic [6:0] ecode_t;

    localparam ecode_t ECODE_SYS = 7'h0B;
    localparam ecode_t ECODE_BRK = 7'h0C;
    localparam ecode_t ECODE_IPE = 7'h0E;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        // passes operand b for lu12i
        ALU_LUI  = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RF   = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2,
        SRC1_TID  = 2'd3
    } src1_sel_e;

    // counter halves feed rdcntvl / rdcntvh
    typedef enum logic [1:0] {
        SRC2_RF     = 2'd0,
        SRC2_IMM    = 2'd1,
        SRC2_CNT_LO = 2'd2,
        SRC2_CNT_HI = 2'd3
    } src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_B    = 4'd7,
        BR_JIRL = 4'd8
    } br_cond_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        src1_sel_e src1;
        src2_sel_e src2;
        br_cond_e  br;
        logic      is_mem;
        logic      mem_wr;
        mem_size_e mem_size;
        logic      is_atom;
        logic      is_bar;
    } ex1_uop_t;

    // one issue slot as seen by the stage
    typedef struct packed {
        word_t    pc;
        word_t    imm;
        reg_idx_t rj;
        reg_idx_t rk;
        word_t    rj_data;
        word_t    rk_data;
        ex1_uop_t uop;
        logic     is_alu;
        logic     is_syscall;
        logic     is_break;
        logic     is_priv;
    } ex1_slot_t;

    // one forwarding source from a later stage
    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        logic     valid;
    } ex1_bypass_t;

    typedef struct packed {
        logic   flag;
        ecode_t code;
        word_t  badv;
    } ex1_excp_t;

    // data cache request with op 0 for read and 1 for write
    typedef struct packed {
        logic       rvalid;
        logic       wvalid;
        logic       op;
        logic [3:0] wstrb;
        word_t      addr;
        word_t      wdata;
        logic       atom;
    } ex1_mem_req_t;

    typedef struct packed {
        logic  dir_fail;
        logic  addr_fail;
        logic  taken;
        word_t pc;
        word_t tpc;
    } ex1_br_res_t;

endpackage

`default_nettype wire

/* hw/ex1_forward.sv */
`timescale 1ns/10ps
`default_nettype none

module ex1_forward #(
    parameter int NUM_BYPASS = 4
) (
    input  wire ex1_pkg::reg_idx_t                     rj_i,
    input  wire ex1_pkg::reg_idx_t                     rk_i,
    input  wire ex1_pkg::word_t                        rj_data_i,
    input  wire ex1_pkg::word_t                        rk_data_i,
    input  wire ex1_pkg::ex1_bypass_t [NUM_BYPASS-1:0] bypass_i,
    output ex1_pkg::word_t                             rj_data_o,
    output ex1_pkg::word_t                             rk_data_o,
    output logic                                       stall_o
);

    // index 0 is rj, index 1 is rk
    ex1_pkg::reg_idx_t [1:0] src_idx;
    ex1_pkg::word_t    [1:0] src_rf;
    ex1_pkg::word_t    [1:0] src_fwd;
    logic              [1:0] src_stall;

    assign src_idx = {rk_i, rj_i};
    assign src_rf  = {rk_data_i, rj_data_i};

    always_comb begin
        logic pending;

        pending   = 1'b0;
        src_fwd   = src_rf;
        src_stall = 2'b00;
        for (int s = 0; s < 2; s++) begin
            // walk from the oldest entry so the lowest index overrides
            for (int e = NUM_BYPASS - 1; e >= 0; e--) begin
                if (src_idx[s] != '0 && bypass_i[e].rd == src_idx[s]) begin
                    src_fwd[s]   = bypass_i[e].data;
                    src_stall[s] = ~bypass_i[e].valid;
                end
            end
        end

        // any unfinished producer for either source at all
        for (int e = 0; e < NUM_BYPASS; e++) begin
            if (bypass_i[e].rd != '0 && !bypass_i[e].valid &&
                (bypass_i[e].rd == rj_i || bypass_i[e].rd == rk_i)) begin
                pending = 1'b1;
            end
        end

        // a stall needs some matching entry that is still in flight
        assert (!(|src_stall) || pending)
            else $error("forward stall without a matching pending producer");
    end

    assign rj_data_o = src_fwd[0];
    assign rk_data_o = src_fwd[1];
    assign stall_o   = |src_stall;

endmodule

`default_nettype wire

/* hw/ex_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
    input  wire ex1_pkg::alu_op_e op_i,
    input  wire ex1_pkg::word_t   a_i,
    input  wire ex1_pkg::word_t   b_i,
    output ex1_pkg::word_t        y_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shift amount comes from the low five bits only
    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ex1_pkg::ALU_ADD: begin
                y_o = a_i + b_i;
            end
            ex1_pkg::ALU_SUB: begin
                y_o = a_i - b_i;
            end
            ex1_pkg::ALU_SLT: begin
                y_o = {31'b0, lt_signed};
            end
            ex1_pkg::ALU_SLTU: begin
                y_o = {31'b0, lt_unsigned};
            end
            ex1_pkg::ALU_AND: begin
                y_o = a_i & b_i;
            end
            ex1_pkg::ALU_OR: begin
                y_o = a_i | b_i;
            end
            ex1_pkg::ALU_NOR: begin
                y_o = ~(a_i | b_i);
            end
            ex1_pkg::ALU_XOR: begin
                y_o = a_i ^ b_i;
            end
            ex1_pkg::ALU_SLL: begin
                y_o = a_i << shamt;
            end
            ex1_pkg::ALU_SRL: begin
                y_o = a_i >> shamt;
            end
            ex1_pkg::ALU_SRA: begin
                y_o = ex1_pkg::word_t'($signed(a_i) >>> shamt);
            end
            ex1_pkg::ALU_LUI: begin
                y_o = b_i;
            end
            default: begin
                y_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/ex_branch.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_branch (
    input  wire ex1_pkg::ex1_slot_t slot_i,
    input  wire ex1_pkg::word_t     rj_data_i,
    input  wire ex1_pkg::word_t     rk_data_i,
    input  wire logic               predict_taken_i,
    input  wire ex1_pkg::word_t     predict_pc_i,
    output ex1_pkg::ex1_br_res_t    res_o
);

    logic           is_br;
    logic           taken;
    ex1_pkg::word_t target;

    assign is_br = slot_i.uop.br != ex1_pkg::BR_NONE;

    // condition on the forwarded operands
    always_comb begin
        case (slot_i.uop.br)
            ex1_pkg::BR_BEQ:  taken = rj_data_i == rk_data_i;
            ex1_pkg::BR_BNE:  taken = rj_data_i != rk_data_i;
            ex1_pkg::BR_BLT:  taken = $signed(rj_data_i) < $signed(rk_data_i);
            ex1_pkg::BR_BGE:  taken = $signed(rj_data_i) >= $signed(rk_data_i);
            ex1_pkg::BR_BLTU: taken = rj_data_i < rk_data_i;
            ex1_pkg::BR_BGEU: taken = rj_data_i >= rk_data_i;
            ex1_pkg::BR_B:    taken = 1'b1;
            ex1_pkg::BR_JIRL: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign target = (slot_i.uop.br == ex1_pkg::BR_JIRL) ? rj_data_i + slot_i.imm
                                                        : slot_i.pc + slot_i.imm;

    always_comb begin
        res_o     = '0;
        res_o.pc  = slot_i.pc;
        if (is_br) begin
            res_o.taken    = taken;
            res_o.tpc      = target;
            res_o.dir_fail = taken != predict_taken_i;
            // only meaningful when both sides agree on taken
            res_o.addr_fail = taken && predict_taken_i && (target != predict_pc_i);
        end
    end

endmodule

`default_nettype wire

/* hw/ex1_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module ex1_stage #(
    parameter int NUM_BYPASS = 4
) (
    input  wire logic                                  aclk,
    input  wire logic                                  aresetn,
    input  wire ex1_pkg::ex1_slot_t                    slot0_i,
    input  wire ex1_pkg::ex1_slot_t                    slot1_i,
    input  wire ex1_pkg::ex1_bypass_t [NUM_BYPASS-1:0] bypass_i,
    input  wire ex1_pkg::word_t                        tid_i,
    input  wire logic                                  plv_i,
    input  wire logic                                  predict_taken_i,
    input  wire ex1_pkg::word_t                        predict_pc_i,
    input  wire ex1_pkg::ex1_excp_t                    excp_i,
    output ex1_pkg::word_t                             alu_result0_o,
    output logic                                       alu_result0_valid_o,
    output ex1_pkg::word_t                             alu_result1_o,
    output logic                                       alu_result1_valid_o,
    output logic                                       ibar_o,
    output logic                                       forward_stall_o,
    output ex1_pkg::ex1_br_res_t                       br_res_o,
    output ex1_pkg::ex1_mem_req_t                      mem_req_o,
    output ex1_pkg::ex1_excp_t                         excp_o
);

    // free running counter read by rdcntv{l,h}
    logic [63:0] stable_cnt;

    ex1_pkg::word_t rj_fwd [2];
    ex1_pkg::word_t rk_fwd [2];
    ex1_pkg::word_t alu_y  [2];
    logic [1:0]     lane_stall;
    logic           is_br0;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    for (genvar l = 0; l < 2; l++) begin : g_lane
        ex1_pkg::ex1_slot_t slot;
        ex1_pkg::word_t     op_a;
        ex1_pkg::word_t     op_b;

        assign slot = (l == 0) ? slot0_i : slot1_i;

        ex1_forward #(
            .NUM_BYPASS (NUM_BYPASS)
        ) u_forward (
            .rj_i      (slot.rj),
            .rk_i      (slot.rk),
            .rj_data_i (slot.rj_data),
            .rk_data_i (slot.rk_data),
            .bypass_i  (bypass_i),
            .rj_data_o (rj_fwd[l]),
            .rk_data_o (rk_fwd[l]),
            .stall_o   (lane_stall[l])
        );

        always_comb begin
            case (slot.uop.src1)
                ex1_pkg::SRC1_RF:   op_a = rj_fwd[l];
                ex1_pkg::SRC1_PC:   op_a = slot.pc;
                ex1_pkg::SRC1_ZERO: op_a = '0;
                default:            op_a = tid_i;
            endcase
        end

        always_comb begin
            case (slot.uop.src2)
                ex1_pkg::SRC2_RF:     op_b = rk_fwd[l];
                ex1_pkg::SRC2_IMM:    op_b = slot.imm;
                ex1_pkg::SRC2_CNT_LO: op_b = stable_cnt[31:0];
                default:              op_b = stable_cnt[63:32];
            endcase
        end

        ex_alu u_alu (
            .op_i (slot.uop.alu_op),
            .a_i  (op_a),
            .b_i  (op_b),
            .y_o  (alu_y[l])
        );
    end

    ex_branch u_branch (
        .slot_i          (slot0_i),
        .rj_data_i       (rj_fwd[0]),
        .rk_data_i       (rk_fwd[0]),
        .predict_taken_i (predict_taken_i),
        .predict_pc_i    (predict_pc_i),
        .res_o           (br_res_o)
    );

    assign forward_stall_o = |lane_stall;

    // branches only issue in lane 0 and write the link value
    assign is_br0              = slot0_i.uop.br != ex1_pkg::BR_NONE;
    assign alu_result0_o       = is_br0 ? slot0_i.pc + 32'd4 : alu_y[0];
    assign alu_result0_valid_o = slot0_i.is_alu | is_br0;
    assign alu_result1_o       = alu_y[1];
    assign alu_result1_valid_o = slot1_i.is_alu;
    assign ibar_o              = slot0_i.uop.is_bar;

    // data cache request from lane 0
    always_comb begin
        mem_req_o        = '0;
        mem_req_o.op     = slot0_i.uop.mem_wr;
        mem_req_o.addr   = rj_fwd[0] + slot0_i.imm;
        mem_req_o.wdata  = rk_fwd[0];
        mem_req_o.atom   = slot0_i.uop.is_atom;
        mem_req_o.rvalid = slot0_i.uop.is_mem & ~slot0_i.uop.mem_wr & ~forward_stall_o;
        mem_req_o.wvalid = slot0_i.uop.is_mem & slot0_i.uop.mem_wr & ~forward_stall_o;
        case (slot0_i.uop.mem_size)
            ex1_pkg::MEM_BYTE: mem_req_o.wstrb = 4'b0001;
            ex1_pkg::MEM_HALF: mem_req_o.wstrb = 4'b0011;
            default:           mem_req_o.wstrb = 4'b1111;
        endcase
    end

    // earlier exceptions win, then syscall, break, privileged in user mode
    always_comb begin
        excp_o = '0;
        if (excp_i.flag) begin
            excp_o = excp_i;
        end else if (slot0_i.is_syscall) begin
            excp_o.flag = 1'b1;
            excp_o.code = ex1_pkg::ECODE_SYS;
            excp_o.badv = slot0_i.pc;
        end else if (slot0_i.is_break) begin
            excp_o.flag = 1'b1;
            excp_o.code = ex1_pkg::ECODE_BRK;
            excp_o.badv = slot0_i.pc;
        end else if (slot0_i.is_priv && plv_i) begin
            excp_o.flag = 1'b1;
            excp_o.code = ex1_pkg::ECODE_IPE;
            excp_o.badv = slot0_i.pc;
        end
    end

    // the cache sees at most one kind of request per cycle
    assert property (@(posedge aclk) disable iff (!aresetn)
        !(mem_req_o.rvalid && mem_req_o.wvalid))
        else $error("dcache read and write requested together");

endmodule

`default_nettype wire

/* dv/tb_ex1_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ex1_stage;

    localparam int NROWS = 27;

    typedef struct {
        ex1_pkg::ex1_slot_t             slot0;
        ex1_pkg::ex1_slot_t             slot1;
        ex1_pkg::ex1_bypass_t [3:0]     byp;
        logic                           plv;
        logic                           ptaken;
        ex1_pkg::word_t                 ppc;
        ex1_pkg::ex1_excp_t             excp;
    } row_t;

    logic                        aclk;
    logic                        aresetn;
    ex1_pkg::ex1_slot_t          slot0;
    ex1_pkg::ex1_slot_t          slot1;
    ex1_pkg::ex1_bypass_t [3:0]  byp;
    ex1_pkg::word_t              tid;
    logic                        plv;
    logic                        ptaken;
    ex1_pkg::word_t              ppc;
    ex1_pkg::ex1_excp_t          excp;
    ex1_pkg::word_t              res0;
    logic                        res0_valid;
    ex1_pkg::word_t              res1;
    logic                        res1_valid;
    logic                        ibar;
    logic                        stall;
    ex1_pkg::ex1_br_res_t        br_res;
    ex1_pkg::ex1_mem_req_t       mem_req;
    ex1_pkg::ex1_excp_t          excp_out;
    logic [31:0]                 rng_state;
    logic [63:0]                 cyc;
    row_t                        rows [NROWS];

    ex1_stage #(
        .NUM_BYPASS (4)
    ) ex1_stage_inst (
        .aclk                (aclk),
        .aresetn             (aresetn),
        .slot0_i             (slot0),
        .slot1_i             (slot1),
        .bypass_i            (byp),
        .tid_i               (tid),
        .plv_i               (plv),
        .predict_taken_i     (ptaken),
        .predict_pc_i        (ppc),
        .excp_i              (excp),
        .alu_result0_o       (res0),
        .alu_result0_valid_o (res0_valid),
        .alu_result1_o       (res1),
        .alu_result1_valid_o (res1_valid),
        .ibar_o              (ibar),
        .forward_stall_o     (stall),
        .br_res_o            (br_res),
        .mem_req_o           (mem_req),
        .excp_o              (excp_out)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #2 aclk = ~aclk;
        end
    end

    initial begin
        aresetn = 1'b0;
        repeat (3) @(posedge aclk);
        #1 aresetn = 1'b1;
    end

    // cycles since reset as the stable counter should report them
    always @(posedge aclk) begin
        if (!aresetn) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 64'd1;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic ex1_pkg::ex1_slot_t mk(input ex1_pkg::alu_op_e op,
                                              input ex1_pkg::src1_sel_e s1,
                                              input ex1_pkg::src2_sel_e s2);
        ex1_pkg::ex1_slot_t s;
        s = '0;
        s.pc = next_rand() & 32'hffff_fffc;
        s.imm = next_rand();
        s.rj = 5'(next_rand());
        s.rk = 5'(next_rand());
        s.rj_data = next_rand();
        s.rk_data = next_rand();
        s.uop.alu_op = op;
        s.uop.src1 = s1;
        s.uop.src2 = s2;
        s.is_alu = 1'b1;
        return s;
    endfunction

    function automatic row_t blank_row();
        row_t r;
        r.slot0 = mk(ex1_pkg::ALU_ADD, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_RF);
        r.slot1 = mk(ex1_pkg::ALU_ADD, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_RF);
        for (int e = 0; e < 4; e++) begin
            r.byp[e].rd = '0;
            r.byp[e].data = next_rand();
            r.byp[e].valid = 1'b1;
        end
        r.plv = 1'b0;
        r.ptaken = 1'b0;
        r.ppc = '0;
        r.excp = '0;
        return r;
    endfunction

    // {stall, data} from the lowest matching nonzero entry or the register file
    function automatic logic [32:0] fwd(input logic [4:0] idx, input logic [31:0] rf,
                                        input ex1_pkg::ex1_bypass_t [3:0] b);
        for (int e = 0; e < 4; e++) begin
            if (idx != 5'd0 && b[e].rd == idx) begin
                return {~b[e].valid, b[e].data};
            end
        end
        return {1'b0, rf};
    endfunction

    function automatic logic [31:0] alu_ref(input ex1_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            ex1_pkg::ALU_ADD:  return a + b;
            ex1_pkg::ALU_SUB:  return a - b;
            ex1_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ex1_pkg::ALU_SLTU: return {31'b0, a < b};
            ex1_pkg::ALU_AND:  return a & b;
            ex1_pkg::ALU_OR:   return a | b;
            ex1_pkg::ALU_NOR:  return ~(a | b);
            ex1_pkg::ALU_XOR:  return a ^ b;
            ex1_pkg::ALU_SLL:  return a << b[4:0];
            ex1_pkg::ALU_SRL:  return a >> b[4:0];
            ex1_pkg::ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
            default:           return b;
        endcase
    endfunction

    function automatic logic [31:0] opnd_a(input ex1_pkg::ex1_slot_t s, input logic [31:0] rj);
        case (s.uop.src1)
            ex1_pkg::SRC1_RF:   return rj;
            ex1_pkg::SRC1_PC:   return s.pc;
            ex1_pkg::SRC1_ZERO: return 32'd0;
            default:            return tid;
        endcase
    endfunction

    function automatic logic [31:0] opnd_b(input ex1_pkg::ex1_slot_t s, input logic [31:0] rk);
        case (s.uop.src2)
            ex1_pkg::SRC2_RF:     return rk;
            ex1_pkg::SRC2_IMM:    return s.imm;
            ex1_pkg::SRC2_CNT_LO: return cyc[31:0];
            default:              return cyc[63:32];
        endcase
    endfunction

    function automatic logic br_taken(input ex1_pkg::br_cond_e c,
                                      input logic [31:0] a, input logic [31:0] b);
        case (c)
            ex1_pkg::BR_BEQ:  return a == b;
            ex1_pkg::BR_BNE:  return a != b;
            ex1_pkg::BR_BLT:  return $signed(a) < $signed(b);
            ex1_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            ex1_pkg::BR_BLTU: return a < b;
            ex1_pkg::BR_BGEU: return a >= b;
            ex1_pkg::BR_NONE: return 1'b0;
            default:          return 1'b1;
        endcase
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_row(input row_t r);
        logic [32:0]           f0j;
        logic [32:0]           f0k;
        logic [32:0]           f1j;
        logic [32:0]           f1k;
        logic                  st;
        logic                  br0;
        logic [31:0]           y0;
        logic [31:0]           y1;
        ex1_pkg::ex1_br_res_t  br;
        ex1_pkg::ex1_mem_req_t mr;
        ex1_pkg::ex1_excp_t    ex;
        f0j = fwd(r.slot0.rj, r.slot0.rj_data, r.byp);
        f0k = fwd(r.slot0.rk, r.slot0.rk_data, r.byp);
        f1j = fwd(r.slot1.rj, r.slot1.rj_data, r.byp);
        f1k = fwd(r.slot1.rk, r.slot1.rk_data, r.byp);
        st = f0j[32] | f0k[32] | f1j[32] | f1k[32];
        br0 = r.slot0.uop.br != ex1_pkg::BR_NONE;
        y0 = alu_ref(r.slot0.uop.alu_op, opnd_a(r.slot0, f0j[31:0]), opnd_b(r.slot0, f0k[31:0]));
        y1 = alu_ref(r.slot1.uop.alu_op, opnd_a(r.slot1, f1j[31:0]), opnd_b(r.slot1, f1k[31:0]));
        // link value replaces the alu result for a branch
        if (br0) begin
            y0 = r.slot0.pc + 32'd4;
        end
        br = '0;
        br.pc = r.slot0.pc;
        if (br0) begin
            br.taken = br_taken(r.slot0.uop.br, f0j[31:0], f0k[31:0]);
            br.tpc = (r.slot0.uop.br == ex1_pkg::BR_JIRL) ? f0j[31:0] + r.slot0.imm
                                                          : r.slot0.pc + r.slot0.imm;
            br.dir_fail = br.taken != r.ptaken;
            br.addr_fail = br.taken && r.ptaken && br.tpc != r.ppc;
        end
        mr = '0;
        mr.op = r.slot0.uop.mem_wr;
        mr.addr = f0j[31:0] + r.slot0.imm;
        mr.wdata = f0k[31:0];
        mr.atom = r.slot0.uop.is_atom;
        mr.rvalid = r.slot0.uop.is_mem && !r.slot0.uop.mem_wr && !st;
        mr.wvalid = r.slot0.uop.is_mem && r.slot0.uop.mem_wr && !st;
        mr.wstrb = (r.slot0.uop.mem_size == ex1_pkg::MEM_BYTE) ? 4'b0001 :
                   (r.slot0.uop.mem_size == ex1_pkg::MEM_HALF) ? 4'b0011 : 4'b1111;
        ex = '0;
        if (r.excp.flag) begin
            ex = r.excp;
        end else if (r.slot0.is_syscall || r.slot0.is_break || (r.slot0.is_priv && r.plv)) begin
            ex.flag = 1'b1;
            ex.code = r.slot0.is_syscall ? ex1_pkg::ECODE_SYS :
                      r.slot0.is_break ? ex1_pkg::ECODE_BRK : ex1_pkg::ECODE_IPE;
            ex.badv = r.slot0.pc;
        end
        check("forward_stall_o", 128'(stall), 128'(st));
        check("alu_result0_o", 128'(res0), 128'(y0));
        check("alu_result0_valid_o", 128'(res0_valid), 128'(r.slot0.is_alu | br0));
        check("alu_result1_o", 128'(res1), 128'(y1));
        check("alu_result1_valid_o", 128'(res1_valid), 128'(r.slot1.is_alu));
        check("ibar_o", 128'(ibar), 128'(r.slot0.uop.is_bar));
        check("br_res_o", 128'(br_res), 128'(br));
        check("mem_req_o", 128'(mem_req), 128'(mr));
        check("excp_o", 128'(excp_out), 128'(ex));
    endtask

    task automatic fill_table();
        for (int i = 0; i < NROWS; i++) begin
            rows[i] = blank_row();
        end
        rows[0].slot1 = mk(ex1_pkg::ALU_SUB, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_IMM);
        rows[1].slot0 = mk(ex1_pkg::ALU_SLT, ex1_pkg::SRC1_PC, ex1_pkg::SRC2_RF);
        rows[1].slot1 = mk(ex1_pkg::ALU_SLTU, ex1_pkg::SRC1_ZERO, ex1_pkg::SRC2_IMM);
        rows[2].slot0 = mk(ex1_pkg::ALU_AND, ex1_pkg::SRC1_TID, ex1_pkg::SRC2_RF);
        rows[2].slot1 = mk(ex1_pkg::ALU_OR, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_CNT_LO);
        rows[3].slot0 = mk(ex1_pkg::ALU_NOR, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_CNT_HI);
        rows[3].slot1 = mk(ex1_pkg::ALU_XOR, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_RF);
        rows[4].slot0 = mk(ex1_pkg::ALU_SLL, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_IMM);
        rows[4].slot1 = mk(ex1_pkg::ALU_SRL, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_RF);
        rows[5].slot0 = mk(ex1_pkg::ALU_SRA, ex1_pkg::SRC1_RF, ex1_pkg::SRC2_RF);
        rows[5].slot1 = mk(ex1_pkg::ALU_LUI, ex1_pkg::SRC1_ZERO, ex1_pkg::SRC2_IMM);
        // forwarding priority between stages
        rows[6].slot0.rj = 5'd5;
        rows[6].slot0.rk = 5'd6;
        rows[6].byp[0].rd = 5'd5;
        rows[6].byp[2].rd = 5'd5;
        rows[6].byp[1].rd = 5'd6;
        rows[6].byp[3].rd = 5'd6;
        // lane 1 wins over lane 0 inside one stage
        rows[7].slot0.rj = 5'd7;
        rows[7].slot0.rk = 5'd8;
        rows[7].slot1.rj = 5'd7;
        rows[7].byp[2].rd = 5'd7;
        rows[7].byp[3].rd = 5'd7;
        rows[7].byp[0].rd = 5'd8;
        rows[7].byp[1].rd = 5'd8;
        rows[8].slot0.rj = 5'd0;
        rows[8].slot0.rk = 5'd0;
        rows[8].byp[0].valid = 1'b0;
        // invalid producer stalls and blocks the store
        rows[9].slot0.rj = 5'd9;
        rows[9].slot1.rk = 5'd9;
        rows[9].slot0.uop.is_mem = 1'b1;
        rows[9].slot0.uop.mem_wr = 1'b1;
        rows[9].byp[2].rd = 5'd9;
        rows[9].byp[2].valid = 1'b0;
        rows[10] = rows[9];
        rows[10].byp[0].rd = 5'd9;
        for (int k = 0; k < 8; k++) begin
            rows[11+k].slot0.is_alu = 1'b0;
            rows[11+k].slot0.uop.br = ex1_pkg::br_cond_e'(k + 1);
            rows[11+k].ptaken = (k % 3) != 1;
            rows[11+k].ppc = (k % 2 == 0) ? rows[11+k].slot0.pc + rows[11+k].slot0.imm
                                          : next_rand();
        end
        rows[11].slot0.rk_data = rows[11].slot0.rj_data;
        rows[18].ptaken = 1'b1;
        rows[18].ppc = rows[18].slot0.rj_data + rows[18].slot0.imm;
        rows[19].slot0.uop.is_mem = 1'b1;
        rows[19].slot0.uop.is_atom = 1'b1;
        rows[19].slot0.uop.mem_size = ex1_pkg::MEM_BYTE;
        rows[20].slot0.uop.is_mem = 1'b1;
        rows[20].slot0.uop.mem_wr = 1'b1;
        rows[20].slot0.uop.mem_size = ex1_pkg::MEM_HALF;
        rows[20].slot0.uop.is_bar = 1'b1;
        rows[21].slot0.uop.is_mem = 1'b1;
        rows[21].slot0.uop.mem_size = ex1_pkg::MEM_WORD;
        rows[22].excp.flag = 1'b1;
        rows[22].excp.code = 7'h21;
        rows[22].excp.badv = next_rand();
        rows[22].slot0.is_syscall = 1'b1;
        rows[23].slot0.is_syscall = 1'b1;
        rows[23].slot0.is_break = 1'b1;
        rows[24].slot0.is_break = 1'b1;
        rows[24].slot0.is_priv = 1'b1;
        rows[24].plv = 1'b1;
        rows[25].slot0.is_priv = 1'b1;
        rows[25].plv = 1'b1;
        rows[26].slot0.is_priv = 1'b1;
    endtask

    initial begin
        int n;
        rng_state = 32'd32359;
        slot0 = '0;
        slot1 = '0;
        byp = '0;
        plv = 1'b0;
        ptaken = 1'b0;
        ppc = '0;
        excp = '0;
        tid = next_rand();
        fill_table();
        n = 0;
        while (aresetn !== 1'b1 && n < 20) begin
            @(posedge aclk);
            n++;
        end
        if (aresetn !== 1'b1) begin
            $display("CHECKS FAILED");
            $fatal(1, "reset was not released in time");
        end
        for (int i = 0; i < NROWS; i++) begin
            #1;
            slot0 = rows[i].slot0;
            slot1 = rows[i].slot1;
            byp = rows[i].byp;
            plv = rows[i].plv;
            ptaken = rows[i].ptaken;
            ppc = rows[i].ppc;
            excp = rows[i].excp;
            #2;
            check_row(rows[i]);
            @(posedge aclk);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/ex1_pkg.sv
hw/ex1_forward.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex1_stage.sv
dv/tb_ex1_stage.sv

/* run.sh */
#!/bin/sh
# build and run the ex1 stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_ex1_stage -o sim_ex1
./obj_dir/sim_ex1
